//--- demod.f
demodPkg.sv
demodCfgIf.sv
demodRegs.sv
demodControl.sv
freqDiscriminator.sv
lockDetector.sv
demodTop.sv
demodTop_assert.sv
demodTb.sv

//--- demodCases.txt
# W addr data lanes | S step count | R addr expected name
# Addresses, data and steps are hex, lanes is the wr3..wr0 mask, count is decimal.
W 004 00030201 1
R 004 00000001 dacLane0
W 004 000f0f0f 6
R 004 000f0f01 dacLanes12
W 008 12345678 5
R 008 00340078 falseLockLanes02
R 020 00000000 unmapped
W 008 00400004 f
R 008 00400004 falseLockFull
W 000 00020003 f
R 000 00020003 controlReadback
R 00c 00000010 stateAcquire
S 0030 5
R 00c 00000021 lockTrack
R 014 00000030 devLock
S 0050 4
R 00c 00000014 offsetAcquire
R 014 00000050 devPeak
W 000 00000003 1
R 014 00000000 devCleared
R 00c 00000010 flagsCleared
W 000 00000000 1
R 00c 00000000 stateIdle
R 000 00020000 modeZero
W 000 00000003 1
S ffd0 5
R 00c 00000021 negStepLock
R 014 00000030 negStepDev

//--- demodCfgIf.sv
`timescale 1ns/1ps

interface demodCfgIf;

    logic [3:0]             demodMode;
    demodPkg::cfgWordT      falseLockAlpha;
    demodPkg::cfgWordT      falseLockThreshold;
    logic                   demodLock;
    logic                   highFreqOffset;
    demodPkg::cfgWordT      fskDeviation;
    demodPkg::demodStateT   state;

    modport regs (
        output demodMode, falseLockAlpha, falseLockThreshold,
        input  demodLock, highFreqOffset, fskDeviation, state
    );

    modport ctrl (
        input  demodMode, demodLock,
        output state
    );

    modport lock (
        input  falseLockAlpha, falseLockThreshold,
        output demodLock, highFreqOffset
    );

endinterface

//--- demodControl.sv
`timescale 1ns/1ps

module demodControl (
    input  logic    clk,
    input  logic    arstN,
    demodCfgIf.ctrl cfg,
    input  logic    controlWrite,
    output logic    run,
    output logic    clear
);

    demodPkg::demodStateT state;
    demodPkg::demodStateT stateNext;
    logic                 clearNext;

    assign cfg.state = state;
    assign run       = (state != demodPkg::stIdle);

    always_comb begin
        stateNext = state;
        clearNext = 1'b0;
        if (cfg.demodMode == 4'h0) begin
            stateNext = demodPkg::stIdle;
        end else if (controlWrite || state == demodPkg::stIdle) begin
            stateNext = demodPkg::stAcquire;
            clearNext = 1'b1;
        end else begin
            case (state)
                // Lock left over from before the clear is not trusted.
                demodPkg::stAcquire:
                    if (cfg.demodLock && !clear) stateNext = demodPkg::stTrack;
                demodPkg::stTrack:
                    if (!cfg.demodLock) stateNext = demodPkg::stAcquire;
                default:
                    stateNext = demodPkg::stIdle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= demodPkg::stIdle;
            clear <= 1'b0;
        end else begin
            state <= stateNext;
            clear <= clearNext;
        end
    end

endmodule

//--- demodPkg.sv
package demodPkg;

    // Bus word and address types.
    typedef logic [11:0] regAddrT;
    typedef logic [31:0] regDataT;

    // Full scale of a phase sample is one turn, so differences wrap naturally.
    typedef logic [15:0] phaseT;
    typedef logic signed [15:0] freqT;

    // Alpha, threshold and the deviation peak all share this width.
    typedef logic [15:0] cfgWordT;

    typedef enum logic [1:0] {
        stIdle    = 2'd0,
        stAcquire = 2'd1,
        stTrack   = 2'd2
    } demodStateT;

    // Register map, one word apart.
    localparam regAddrT demodControlAddr   = 12'h000;
    localparam regAddrT demodDacSelectAddr = 12'h004;
    localparam regAddrT demodFalseLockAddr = 12'h008;
    localparam regAddrT demodStatusAddr    = 12'h00C;
    localparam regAddrT demodAmTcAddr      = 12'h010;
    localparam regAddrT demodFskDevAddr    = 12'h014;

endpackage

//--- demodRegs.sv
`timescale 1ns/1ps

module demodRegs (
    input  logic                clk,
    input  logic                arstN,
    input  demodPkg::regAddrT   addr,
    input  demodPkg::regDataT   dataIn,
    output demodPkg::regDataT   dataOut,
    input  logic                cs,
    input  logic                wr0,
    input  logic                wr1,
    input  logic                wr2,
    input  logic                wr3,
    demodCfgIf.regs             cfg,
    input  demodPkg::cfgWordT   fskDeviation,
    output logic                controlWrite,
    output logic [1:0]          bitsyncMode,
    output logic [3:0]          dac0Select,
    output logic [3:0]          dac1Select,
    output logic [3:0]          dac2Select,
    output logic [4:0]          amTC
);

    logic [3:0]         demodMode;
    demodPkg::cfgWordT  falseLockAlpha;
    demodPkg::cfgWordT  falseLockThreshold;

    assign cfg.demodMode          = demodMode;
    assign cfg.falseLockAlpha     = falseLockAlpha;
    assign cfg.falseLockThreshold = falseLockThreshold;

    // Each strobe writes only its own byte lane of the addressed register.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            demodMode          <= '0;
            bitsyncMode        <= '0;
            dac0Select         <= '0;
            dac1Select         <= '0;
            dac2Select         <= '0;
            falseLockAlpha     <= '0;
            falseLockThreshold <= '0;
            amTC               <= '0;
            controlWrite       <= 1'b0;
        end else begin
            controlWrite <= cs && wr0 && (addr == demodPkg::demodControlAddr);
            if (cs) begin
                if (wr0) begin
                    case (addr)
                        demodPkg::demodControlAddr:   demodMode <= dataIn[3:0];
                        demodPkg::demodDacSelectAddr: dac0Select <= dataIn[3:0];
                        demodPkg::demodFalseLockAddr: falseLockAlpha[7:0] <= dataIn[7:0];
                        demodPkg::demodAmTcAddr:      amTC <= dataIn[4:0];
                        default: ;
                    endcase
                end
                if (wr1) begin
                    case (addr)
                        demodPkg::demodDacSelectAddr: dac1Select <= dataIn[11:8];
                        demodPkg::demodFalseLockAddr: falseLockAlpha[15:8] <= dataIn[15:8];
                        default: ;
                    endcase
                end
                if (wr2) begin
                    case (addr)
                        demodPkg::demodControlAddr:   bitsyncMode <= dataIn[17:16];
                        demodPkg::demodDacSelectAddr: dac2Select <= dataIn[19:16];
                        demodPkg::demodFalseLockAddr: falseLockThreshold[7:0] <= dataIn[23:16];
                        default: ;
                    endcase
                end
                if (wr3) begin
                    if (addr == demodPkg::demodFalseLockAddr) begin
                        falseLockThreshold[15:8] <= dataIn[31:24];
                    end
                end
            end
        end
    end

    // The two bit-sync lock positions now carry the acquisition state.
    always_comb begin
        dataOut = '0;
        if (cs) begin
            case (addr)
                demodPkg::demodControlAddr:
                    dataOut = {14'h0, bitsyncMode, 12'h0, demodMode};
                demodPkg::demodDacSelectAddr:
                    dataOut = {12'h0, dac2Select, 4'h0, dac1Select, 4'h0, dac0Select};
                demodPkg::demodFalseLockAddr:
                    dataOut = {falseLockThreshold, falseLockAlpha};
                demodPkg::demodStatusAddr:
                    dataOut = {26'h0, cfg.state, 1'b0, cfg.highFreqOffset,
                               1'b0, cfg.demodLock};
                demodPkg::demodAmTcAddr:
                    dataOut = {27'h0, amTC};
                demodPkg::demodFskDevAddr:
                    dataOut = {16'h0, fskDeviation};
                default:
                    dataOut = '0;
            endcase
        end
    end

endmodule

//--- demodTb.sv
`timescale 1ns/1ps

module demodTb;

    logic               clk;
    logic               arstN;
    demodPkg::regAddrT  addr;
    demodPkg::regDataT  dataIn;
    demodPkg::regDataT  dataOut;
    logic               cs;
    logic               wr0;
    logic               wr1;
    logic               wr2;
    logic               wr3;
    logic               sampleValid;
    demodPkg::phaseT    phase;
    logic [1:0]         bitsyncMode;
    logic [3:0]         dac0Select;
    logic [3:0]         dac1Select;
    logic [3:0]         dac2Select;
    logic [4:0]         amTC;

    int                 caseLines;
    int                 passCount;
    int                 failCount;
    int                 errorCount;
    demodPkg::phaseT    phaseAcc;

    // Written words of the registers whose fields also leave the block as ports.
    demodPkg::regDataT  ctrlShadow;
    demodPkg::regDataT  dacShadow;
    demodPkg::regDataT  amTcShadow;

    demodTop i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Each set bit of the mask replaces one byte lane of the old word.
    function automatic demodPkg::regDataT laneMerge(input demodPkg::regDataT old,
                                                    input demodPkg::regDataT d,
                                                    input logic [3:0] mask);
        demodPkg::regDataT merged;
        merged = old;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                merged[8*i +: 8] = d[8*i +: 8];
            end
        end
        return merged;
    endfunction

    task automatic busWrite(input demodPkg::regAddrT a, input demodPkg::regDataT d,
                            input logic [3:0] mask);
        @(negedge clk);
        addr   = a;
        dataIn = d;
        cs     = 1'b1;
        {wr3, wr2, wr1, wr0} = mask;
        case (a)
            demodPkg::demodControlAddr:   ctrlShadow = laneMerge(ctrlShadow, d, mask);
            demodPkg::demodDacSelectAddr: dacShadow  = laneMerge(dacShadow, d, mask);
            demodPkg::demodAmTcAddr:      amTcShadow = laneMerge(amTcShadow, d, mask);
            default: ;
        endcase
        @(negedge clk);
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'h0;
        // A control write clears the datapath two edges later.
        repeat (2) @(negedge clk);
    endtask

    // Constant phase step, so every sample after the first gives the same frequency.
    task automatic driveSamples(input demodPkg::phaseT step, input int count);
        repeat (count) begin
            @(negedge clk);
            cs          = 1'b0;
            phaseAcc    = phaseAcc + step;
            phase       = phaseAcc;
            sampleValid = 1'b1;
        end
        @(negedge clk);
        sampleValid = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    task automatic checkRead(input demodPkg::regAddrT a, input demodPkg::regDataT expected,
                             input logic [8*32-1:0] name);
        demodPkg::regDataT got;
        logic [18:0]       portsGot;
        logic [18:0]       portsExp;
        logic              ok;
        @(negedge clk);
        addr = a;
        cs   = 1'b1;
        #1;
        got      = dataOut;
        portsGot = {bitsyncMode, dac2Select, dac1Select, dac0Select, amTC};
        portsExp = {ctrlShadow[17:16], dacShadow[19:16], dacShadow[11:8], dacShadow[3:0],
                    amTcShadow[4:0]};
        assert (got === expected) else begin
            $display("MISMATCH at %0t: %0s addr %h expected %h got %h",
                     $time, name, a, expected, got);
        end
        assert (portsGot === portsExp) else begin
            $display("MISMATCH at %0t: %0s register ports expected %h got %h",
                     $time, name, portsExp, portsGot);
        end
        ok = (got === expected) && (portsGot === portsExp);
        if (ok) begin
            passCount++;
            $display("PASS %0s", name);
        end else begin
            failCount++;
            $display("FAIL %0s", name);
        end
    endtask

    initial begin : mainSeq
        int                 fd;
        int                 code;
        logic [7:0]         cmd;
        logic [8*32-1:0]    name;
        logic [8*128-1:0]   lineBuf;
        demodPkg::regAddrT  a;
        demodPkg::regDataT  d;
        logic [3:0]         mask;
        demodPkg::phaseT    step;
        int                 count;
        arstN       = 1'b0;
        addr        = '0;
        dataIn      = '0;
        cs          = 1'b0;
        wr0         = 1'b0;
        wr1         = 1'b0;
        wr2         = 1'b0;
        wr3         = 1'b0;
        sampleValid = 1'b0;
        phase       = '0;
        phaseAcc    = '0;
        ctrlShadow  = '0;
        dacShadow   = '0;
        amTcShadow  = '0;
        caseLines   = 0;
        passCount   = 0;
        failCount   = 0;
        errorCount  = 0;
        fd = $fopen("demodCases.txt", "r");
        if (fd == 0) begin
            $display("Error: the cases file demodCases.txt could not be opened");
            errorCount++;
        end else begin
            while ($fgets(lineBuf, fd) > 0) begin
                caseLines++;
            end
            $fclose(fd);
            fd = $fopen("demodCases.txt", "r");
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        while (fd != 0 && $fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
                code = $fgets(lineBuf, fd);
            end else if (cmd == "W") begin
                code = $fscanf(fd, "%h %h %h", a, d, mask);
                busWrite(a, d, mask);
            end else if (cmd == "S") begin
                code = $fscanf(fd, "%h %d", step, count);
                driveSamples(step, count);
            end else if (cmd == "R") begin
                code = $fscanf(fd, "%h %h %s", a, d, name);
                checkRead(a, d, name);
            end else begin
                $display("Error: unknown command %0s in demodCases.txt", cmd);
                errorCount++;
                code = $fgets(lineBuf, fd);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("Reads passed %0d, failed %0d, other errors %0d",
                 passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        // The case lines are counted before reset is released.
        @(posedge arstN);
        repeat (caseLines * 20 + 100) @(posedge clk);
        $display("Timeout: the cases did not finish within %0d cycles", caseLines * 20 + 100);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- demodTop.sv
`timescale 1ns/1ps

module demodTop (
    input  logic                clk,
    input  logic                arstN,
    input  demodPkg::regAddrT   addr,
    input  demodPkg::regDataT   dataIn,
    output demodPkg::regDataT   dataOut,
    input  logic                cs,
    input  logic                wr0,
    input  logic                wr1,
    input  logic                wr2,
    input  logic                wr3,
    input  logic                sampleValid,
    input  demodPkg::phaseT     phase,
    output logic [1:0]          bitsyncMode,
    output logic [3:0]          dac0Select,
    output logic [3:0]          dac1Select,
    output logic [3:0]          dac2Select,
    output logic [4:0]          amTC
);

    demodCfgIf cfgIf ();

    logic               controlWrite;
    logic               run;
    logic               clear;
    logic               freqValid;
    demodPkg::cfgWordT  freqMag;

    demodRegs i_regs (
        .clk          (clk),
        .arstN        (arstN),
        .addr         (addr),
        .dataIn       (dataIn),
        .dataOut      (dataOut),
        .cs           (cs),
        .wr0          (wr0),
        .wr1          (wr1),
        .wr2          (wr2),
        .wr3          (wr3),
        .cfg          (cfgIf.regs),
        .fskDeviation (cfgIf.fskDeviation),
        .controlWrite (controlWrite),
        .bitsyncMode  (bitsyncMode),
        .dac0Select   (dac0Select),
        .dac1Select   (dac1Select),
        .dac2Select   (dac2Select),
        .amTC         (amTC)
    );

    demodControl i_control (
        .clk          (clk),
        .arstN        (arstN),
        .cfg          (cfgIf.ctrl),
        .controlWrite (controlWrite),
        .run          (run),
        .clear        (clear)
    );

    freqDiscriminator i_freq (
        .clk          (clk),
        .arstN        (arstN),
        .run          (run),
        .clear        (clear),
        .sampleValid  (sampleValid),
        .phase        (phase),
        .freqValid    (freqValid),
        .fskDeviation (cfgIf.fskDeviation),
        .freqMag      (freqMag)
    );

    lockDetector i_lock (
        .clk          (clk),
        .arstN        (arstN),
        .clear        (clear),
        .freqValid    (freqValid),
        .freqMag      (freqMag),
        .cfg          (cfgIf.lock)
    );

endmodule

//--- demodTop_assert.sv
`timescale 1ns/1ps

module demodTopAssert (
    input logic                 clk,
    input logic                 arstN,
    input logic                 cs,
    input demodPkg::regDataT    dataOut,
    input logic                 demodLock,
    input logic                 highFreqOffset,
    input demodPkg::demodStateT state,
    input logic                 freqValid,
    input demodPkg::cfgWordT    fskDeviation
);

    // Readback is gated by chip select.
    assert property (@(posedge clk) disable iff (!arstN) !cs |-> dataOut == '0)
        else $error("dataOut is not zero while cs is low");

    assert property (@(posedge clk) disable iff (!arstN) !(demodLock && highFreqOffset))
        else $error("demodLock and highFreqOffset are high together");

    // An idle block holds its peak and its flags.
    assert property (@(posedge clk) disable iff (!arstN)
        (state == demodPkg::stIdle && !freqValid) |=>
            ($stable(demodLock) && $stable(highFreqOffset) && $stable(fskDeviation)))
        else $error("datapath state changed while idle");

endmodule

bind demodTop demodTopAssert i_assert (
    .clk            (clk),
    .arstN          (arstN),
    .cs             (cs),
    .dataOut        (dataOut),
    .demodLock      (cfgIf.demodLock),
    .highFreqOffset (cfgIf.highFreqOffset),
    .state          (cfgIf.state),
    .freqValid      (freqValid),
    .fskDeviation   (cfgIf.fskDeviation)
);

//--- freqDiscriminator.sv
`timescale 1ns/1ps

module freqDiscriminator (
    input  logic                clk,
    input  logic                arstN,
    input  logic                run,
    input  logic                clear,
    input  logic                sampleValid,
    input  demodPkg::phaseT     phase,
    output logic                freqValid,
    output demodPkg::cfgWordT   fskDeviation,
    output demodPkg::cfgWordT   freqMag
);

    demodPkg::phaseT    prevPhase;
    logic               havePrev;
    demodPkg::freqT     freq;
    demodPkg::cfgWordT  freqAbs;

    // Modulo subtraction gives the shortest signed step around the circle.
    assign freq    = demodPkg::freqT'(phase - prevPhase);
    assign freqAbs = freq[15] ? demodPkg::cfgWordT'(-freq) : demodPkg::cfgWordT'(freq);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            havePrev     <= 1'b0;
            freqValid    <= 1'b0;
            fskDeviation <= '0;
        end else if (clear) begin
            havePrev     <= 1'b0;
            freqValid    <= 1'b0;
            fskDeviation <= '0;
        end else begin
            freqValid <= sampleValid && run && havePrev;
            if (sampleValid && run) begin
                havePrev <= 1'b1;
                if (havePrev && freqAbs > fskDeviation) begin
                    fskDeviation <= freqAbs;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sampleValid && run) begin
            prevPhase <= phase;
            freqMag   <= freqAbs;
        end
    end

endmodule

//--- lockDetector.sv
`timescale 1ns/1ps

module lockDetector (
    input  logic                clk,
    input  logic                arstN,
    input  logic                clear,
    input  logic                freqValid,
    input  demodPkg::cfgWordT   freqMag,
    demodCfgIf.lock             cfg
);

    demodPkg::cfgWordT  inCount;
    demodPkg::cfgWordT  outCount;
    demodPkg::cfgWordT  alphaEff;
    logic               inBand;
    logic               lockFlag;
    logic               offsetFlag;

    // Counters stick at full scale instead of wrapping.
    function automatic demodPkg::cfgWordT satInc(input demodPkg::cfgWordT count);
        return (&count) ? count : count + 16'd1;
    endfunction

    assign alphaEff = (cfg.falseLockAlpha == '0) ? 16'd1 : cfg.falseLockAlpha;
    assign inBand   = (freqMag <= cfg.falseLockThreshold);

    assign cfg.demodLock      = lockFlag;
    assign cfg.highFreqOffset = offsetFlag;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            inCount    <= '0;
            outCount   <= '0;
            lockFlag   <= 1'b0;
            offsetFlag <= 1'b0;
        end else if (clear) begin
            inCount    <= '0;
            outCount   <= '0;
            lockFlag   <= 1'b0;
            offsetFlag <= 1'b0;
        end else if (freqValid) begin
            if (inBand) begin
                inCount    <= satInc(inCount);
                outCount   <= '0;
                offsetFlag <= 1'b0;
                if (satInc(inCount) >= alphaEff) lockFlag <= 1'b1;
            end else begin
                outCount <= satInc(outCount);
                inCount  <= '0;
                lockFlag <= 1'b0;
                if (satInc(outCount) >= alphaEff) offsetFlag <= 1'b1;
            end
        end
    end

endmodule

//--- runSim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module demodTb -f demod.f -o demodSim
./obj_dir/demodSim 2>&1 | tee sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
